/* Bender.yml */
package:
  name: pu

sources:
  - design/pu_pkg.sv
  - design/pu_weight_loader.sv
  - design/weight_buffer.sv
  - design/pu_ctrl_pipe.sv
  - design/pe.sv
  - design/pu_output_stage.sv
  - design/pu_top.sv
  - target: simulation
    files:
      - tb/pu_props.sv
      - tb/tb_pu.sv

/* design/pe.sv */
`timescale 1ns/1ps

module pe (
  input  logic           clk,
  input  logic           reset,
  input  pu_pkg::pe_op_t op,
  input  pu_pkg::op_t    operand,
  input  pu_pkg::op_t    weight,
  input  pu_pkg::op_t    bias,
  input  logic           mask,
  output pu_pkg::op_t    result
);

  import pu_pkg::*;

  logic signed [2*OP_W-1:0] product;
  acc_t                     prod_ext;  // masked, sign-extended product
  acc_t                     acc;
  logic                     pos_ovf;
  logic                     neg_ovf;

  assign product  = $signed(operand) * $signed(weight);
  assign prod_ext = mask ? acc_t'(product) : '0;  // masked PE adds nothing

  // ==================================================
  // accumulator
  // ==================================================
  always_ff @(posedge clk)
  begin
    if (reset)
      acc <= '0;
    else
    begin
      case (op)
        PE_CLEAR: acc <= acc_t'($signed(bias)) + prod_ext;
        PE_MAC:   acc <= acc + prod_ext;
        default:  acc <= acc;  // idle and out hold
      endcase
    end
  end

  // ==================================================
  // saturation to 16 bits
  // ==================================================
  // upper bits must all match the sign of the 16-bit result
  assign pos_ovf = !acc[ACC_W-1] && (|acc[ACC_W-2:OP_W-1]);
  assign neg_ovf =  acc[ACC_W-1] && !(&acc[ACC_W-2:OP_W-1]);

  always_comb
  begin
    if (pos_ovf)
      result = {1'b0, {(OP_W-1){1'b1}}};  // 0x7fff
    else if (neg_ovf)
      result = {1'b1, {(OP_W-1){1'b0}}};  // 0x8000
    else
      result = acc[OP_W-1:0];
  end

endmodule

/* design/pu_ctrl_pipe.sv */
`timescale 1ns/1ps

module pu_ctrl_pipe (
  input  logic                clk,
  input  logic                reset,
  input  pu_pkg::pe_op_t      pe_op,
  input  pu_pkg::wb_rd_addr_t wb_read_addr,
  input  pu_pkg::vec_t        vec_data,
  input  pu_pkg::pe_mask_t    vec_mask,
  output logic                wb_read_req,
  output pu_pkg::wb_rd_addr_t wb_read_addr_d,
  output pu_pkg::pe_op_t      op_d,
  output pu_pkg::vec_t        vec_data_d,
  output pu_pkg::pe_mask_t    vec_mask_d
);

  import pu_pkg::*;

  // stage 1 copies of the command
  pe_op_t   op_s1;
  vec_t     vec_data_s1;
  pe_mask_t vec_mask_s1;

  // ==================================================
  // stage 1: sample command, issue weight read
  // ==================================================
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      op_s1       <= PE_IDLE;
      wb_read_req <= 1'b0;
    end
    else
    begin
      op_s1       <= pe_op;
      wb_read_req <= (pe_op == PE_CLEAR) || (pe_op == PE_MAC);  // only these need a weight
    end
  end

  always_ff @(posedge clk)
  begin
    wb_read_addr_d <= wb_read_addr;
    vec_data_s1    <= vec_data;
    vec_mask_s1    <= vec_mask;
  end

  // ==================================================
  // stage 2: meets the registered weight
  // ==================================================
  always_ff @(posedge clk)
  begin
    if (reset)
      op_d <= PE_IDLE;
    else
      op_d <= op_s1;
  end

  always_ff @(posedge clk)
  begin
    vec_data_d <= vec_data_s1;
    vec_mask_d <= vec_mask_s1;
  end

endmodule

/* design/pu_output_stage.sv */
`timescale 1ns/1ps

module pu_output_stage (
  input  logic           clk,
  input  logic           reset,
  input  pu_pkg::pe_op_t op,
  input  pu_pkg::vec_t   results,
  output pu_pkg::vec_t   write_data,
  output logic           write_req
);

  import pu_pkg::*;

  logic emit;

  assign emit = (op == PE_OUT);

  // one strobe per PE_OUT, no back-pressure
  always_ff @(posedge clk)
  begin
    if (reset)
      write_req <= 1'b0;
    else
      write_req <= emit;
  end

  // vector held until the next PE_OUT
  always_ff @(posedge clk)
  begin
    if (emit)
      write_data <= results;
  end

endmodule

/* design/pu_pkg.sv */
package pu_pkg;

  // ==================================================
  // widths
  // ==================================================
  localparam int OP_W         = 16;  // operand, weight and bias
  localparam int NUM_PE       = 4;
  localparam int ACC_W        = 40;
  localparam int BUS_W        = 64;  // read bus word
  localparam int WB_WR_ADDR_W = 5;   // 32 words
  localparam int WB_RD_ADDR_W = 7;   // word address + weight select
  localparam int READ_ID_W    = 4;

  // identifier this unit answers to on the read bus
  localparam int PU_ID = 0;

  // ==================================================
  // types
  // ==================================================
  typedef logic [OP_W-1:0]         op_t;
  typedef logic signed [ACC_W-1:0] acc_t;
  typedef logic [NUM_PE*OP_W-1:0]  vec_t;         // PE i on slice i
  typedef logic [BUS_W-1:0]        bus_word_t;
  typedef logic [WB_WR_ADDR_W-1:0] wb_wr_addr_t;
  typedef logic [WB_RD_ADDR_W-1:0] wb_rd_addr_t;
  typedef logic [READ_ID_W-1:0]    read_id_t;
  typedef logic [NUM_PE-1:0]       pe_mask_t;

  // PE operation codes
  typedef enum logic [1:0] {
    PE_IDLE  = 2'd0,
    PE_CLEAR = 2'd1,  // bias + product
    PE_MAC   = 2'd2,  // accumulate product
    PE_OUT   = 2'd3   // emit saturated accumulators
  } pe_op_t;

endpackage

/* design/pu_top.sv */
`timescale 1ns/1ps

module pu_top (
  input  logic                clk,
  input  logic                reset,
  // load path
  input  logic                bias_read_req,
  input  pu_pkg::bus_word_t   read_data,
  input  pu_pkg::read_id_t    read_id,
  input  logic                read_data_valid,
  output logic                read_req,
  // compute path
  input  pu_pkg::pe_op_t      pe_op,
  input  pu_pkg::wb_rd_addr_t wb_read_addr,
  input  pu_pkg::vec_t        vec_data,
  input  pu_pkg::pe_mask_t    vec_mask,
  output pu_pkg::vec_t        write_data,
  output logic                write_req
);

  import pu_pkg::*;

  // loader to buffer
  logic        wb_write_req;
  wb_wr_addr_t wb_write_addr;
  bus_word_t   wb_write_data;
  op_t         active_bias;

  // pipe to buffer and PEs
  logic        wb_read_req;
  wb_rd_addr_t wb_read_addr_d;
  op_t         weight;         // shared by all PEs
  pe_op_t      op_d;
  vec_t        vec_data_d;
  pe_mask_t    vec_mask_d;
  vec_t        pe_results;

  // ==================================================
  // load path
  // ==================================================
  pu_weight_loader u_loader (
    .clk             (clk),
    .reset           (reset),
    .bias_read_req   (bias_read_req),
    .read_data       (read_data),
    .read_id         (read_id),
    .read_data_valid (read_data_valid),
    .read_req        (read_req),
    .wb_write_req    (wb_write_req),
    .wb_write_addr   (wb_write_addr),
    .wb_write_data   (wb_write_data),
    .active_bias     (active_bias)
  );

  weight_buffer u_wb (
    .clk        (clk),
    .write_req  (wb_write_req),
    .write_addr (wb_write_addr),
    .write_data (wb_write_data),
    .read_req   (wb_read_req),
    .read_addr  (wb_read_addr_d),
    .read_data  (weight)
  );

  // ==================================================
  // compute path
  // ==================================================
  pu_ctrl_pipe u_pipe (
    .clk            (clk),
    .reset          (reset),
    .pe_op          (pe_op),
    .wb_read_addr   (wb_read_addr),
    .vec_data       (vec_data),
    .vec_mask       (vec_mask),
    .wb_read_req    (wb_read_req),
    .wb_read_addr_d (wb_read_addr_d),
    .op_d           (op_d),
    .vec_data_d     (vec_data_d),
    .vec_mask_d     (vec_mask_d)
  );

  for (genvar i = 0; i < NUM_PE; i++)
  begin : gen_pe
    pe u_pe (
      .clk     (clk),
      .reset   (reset),
      .op      (op_d),
      .operand (vec_data_d[i*OP_W +: OP_W]),
      .weight  (weight),
      .bias    (active_bias),
      .mask    (vec_mask_d[i]),
      .result  (pe_results[i*OP_W +: OP_W])
    );
  end

  pu_output_stage u_out (
    .clk        (clk),
    .reset      (reset),
    .op         (op_d),
    .results    (pe_results),
    .write_data (write_data),
    .write_req  (write_req)
  );

endmodule

/* design/pu_weight_loader.sv */
`timescale 1ns/1ps

module pu_weight_loader (
  input  logic              clk,
  input  logic              reset,
  input  logic              bias_read_req,
  input  pu_pkg::bus_word_t read_data,
  input  pu_pkg::read_id_t  read_id,
  input  logic              read_data_valid,
  output logic              read_req,
  output logic              wb_write_req,
  output pu_pkg::wb_wr_addr_t wb_write_addr,
  output pu_pkg::bus_word_t wb_write_data,
  output pu_pkg::op_t       active_bias
);

  import pu_pkg::*;

  logic accept;       // word for this unit
  logic bias_seen;    // first word of the load already taken
  op_t  loaded_bias;

  // ==================================================
  // bus acceptance
  // ==================================================
  assign accept   = read_data_valid && (read_id == read_id_t'(PU_ID));
  assign read_req = accept;

  // everything after the bias word goes to the weight buffer
  assign wb_write_req  = accept && bias_seen;
  assign wb_write_data = read_data;

  always_ff @(posedge clk)
  begin
    if (reset)
      bias_seen <= 1'b0;
    else if (bias_read_req)
      bias_seen <= 1'b0;  // next load starts with a bias again
    else if (accept)
      bias_seen <= 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      loaded_bias <= '0;
    else if (accept && !bias_seen)
      loaded_bias <= read_data[OP_W-1:0];  // low lane carries the bias
  end

  // ==================================================
  // write pointer and bias commit
  // ==================================================
  always_ff @(posedge clk)
  begin
    if (reset)
      wb_write_addr <= '0;
    else if (bias_read_req)
      wb_write_addr <= '0;
    else if (wb_write_req)
      wb_write_addr <= wb_write_addr + 1'b1;
  end

  // bias used by the PEs from now on
  always_ff @(posedge clk)
  begin
    if (reset)
      active_bias <= '0;
    else if (bias_read_req)
      active_bias <= loaded_bias;
  end

endmodule

/* design/weight_buffer.sv */
`timescale 1ns/1ps

module weight_buffer (
  input  logic                clk,
  input  logic                write_req,
  input  pu_pkg::wb_wr_addr_t write_addr,
  input  pu_pkg::bus_word_t   write_data,
  input  logic                read_req,
  input  pu_pkg::wb_rd_addr_t read_addr,
  output pu_pkg::op_t         read_data
);

  import pu_pkg::*;

  bus_word_t mem [2**WB_WR_ADDR_W];

  wb_wr_addr_t                              rd_word;
  logic [WB_RD_ADDR_W-WB_WR_ADDR_W-1:0]     rd_lane;  // weight within the word

  assign rd_word = read_addr[WB_RD_ADDR_W-1 -: WB_WR_ADDR_W];
  assign rd_lane = read_addr[WB_RD_ADDR_W-WB_WR_ADDR_W-1:0];

  // full bus words in
  always_ff @(posedge clk)
  begin
    if (write_req)
      mem[write_addr] <= write_data;
  end

  // one weight out, held between reads
  always_ff @(posedge clk)
  begin
    if (read_req)
      read_data <= mem[rd_word][rd_lane*OP_W +: OP_W];
  end

endmodule

/* src.f */
design/pu_pkg.sv
design/pu_weight_loader.sv
design/weight_buffer.sv
design/pu_ctrl_pipe.sv
design/pe.sv
design/pu_output_stage.sv
design/pu_top.sv
tb/pu_props.sv
tb/tb_pu.sv

/* tb/pu_props.sv */
`timescale 1ns/1ps

module pu_props (
  input logic             clk,
  input logic             reset,
  input pu_pkg::pe_op_t   pe_op,
  input logic             read_req,
  input logic             read_data_valid,
  input pu_pkg::read_id_t read_id,
  input logic             write_req,
  input pu_pkg::vec_t     write_data
);

  import pu_pkg::*;

  int unsigned fail_count = 0;  // read by the testbench

  // strobe set two edges after the sampling edge, seen one edge later
  a_write_after_out: assert property (
    @(posedge clk) disable iff (reset)
    write_req |-> $past(pe_op, 3) == PE_OUT
  )
  else
  begin
    $error("write_req without a PE_OUT sampled two edges before");
    fail_count++;
  end

  a_read_req_match: assert property (
    @(posedge clk) disable iff (reset)
    read_req |-> read_data_valid && (read_id == read_id_t'(PU_ID))
  )
  else
  begin
    $error("read_req without a valid word for this unit");
    fail_count++;
  end

  a_write_data_known: assert property (
    @(posedge clk) disable iff (reset)
    write_req |-> !$isunknown(write_data)
  )
  else
  begin
    $error("write_data has unknown bits during write_req");
    fail_count++;
  end

endmodule

bind pu_top pu_props u_props (
  .clk             (clk),
  .reset           (reset),
  .pe_op           (pe_op),
  .read_req        (read_req),
  .read_data_valid (read_data_valid),
  .read_id         (read_id),
  .write_req       (write_req),
  .write_data      (write_data)
);

/* tb/tb_pu.sv */
`timescale 1ns/1ps

module tb_pu;

  import pu_pkg::*;

  logic        clk;
  logic        reset;
  logic        bias_read_req;
  bus_word_t   read_data;
  read_id_t    read_id;
  logic        read_data_valid;
  logic        read_req;
  pe_op_t      pe_op;
  wb_rd_addr_t wb_read_addr;
  vec_t        vec_data;
  pe_mask_t    vec_mask;
  vec_t        write_data;
  logic        write_req;

  // ==================================================
  // reference model state
  // ==================================================
  bus_word_t   ref_mem [2**WB_WR_ADDR_W];
  wb_wr_addr_t ref_wr_addr;
  logic        ref_bias_seen;
  op_t         ref_loaded_bias;
  op_t         ref_active_bias;
  longint      ref_acc [NUM_PE];
  int          loaded_words;     // weight words of the last load

  vec_t        exp_data_q [$];
  int unsigned exp_edge_q [$];
  int unsigned edge_count = 0;

  pu_top i_pu_top (
    .clk             (clk),
    .reset           (reset),
    .bias_read_req   (bias_read_req),
    .read_data       (read_data),
    .read_id         (read_id),
    .read_data_valid (read_data_valid),
    .read_req        (read_req),
    .pe_op           (pe_op),
    .wb_read_addr    (wb_read_addr),
    .vec_data        (vec_data),
    .vec_mask        (vec_mask),
    .write_data      (write_data),
    .write_req       (write_req)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk)
    edge_count <= edge_count + 1;

  task automatic fail_stop(input string what);
    $display("%s", what);
    $display("Checks failed");
    $fatal(1, "stopped at first error");
  endtask

  // saturated accumulators, one lane per PE
  function automatic vec_t expected_vector();
    vec_t v;
    for (int i = 0; i < NUM_PE; i++)
    begin
      if (ref_acc[i] > 32767)
        v[i*OP_W +: OP_W] = 16'h7fff;
      else if (ref_acc[i] < -32768)
        v[i*OP_W +: OP_W] = 16'h8000;
      else
        v[i*OP_W +: OP_W] = op_t'(ref_acc[i]);
    end
    return v;
  endfunction

  function automatic bus_word_t small_word();
    bus_word_t  w;
    logic [7:0] b;
    for (int i = 0; i < NUM_PE; i++)
    begin
      b = 8'($urandom);
      w[i*OP_W +: OP_W] = {{8{b[7]}}, b};  // keeps sums unsaturated
    end
    return w;
  endfunction

  function automatic wb_rd_addr_t rand_addr();
    return wb_rd_addr_t'($urandom_range(0, loaded_words*4 - 1));
  endfunction

  task automatic apply_cmd(input pe_op_t op, input wb_rd_addr_t addr, input vec_t data,
                           input pe_mask_t mask);
    op_t    wt;
    op_t    opnd;
    longint p;
    wt = ref_mem[addr / 4][(addr % 4)*OP_W +: OP_W];
    for (int i = 0; i < NUM_PE; i++)
    begin
      opnd = data[i*OP_W +: OP_W];
      p = mask[i] ? longint'($signed(opnd)) * longint'($signed(wt)) : longint'(0);
      if (op == PE_CLEAR)
        ref_acc[i] = longint'($signed(ref_active_bias)) + p;
      else if (op == PE_MAC)
        ref_acc[i] = ref_acc[i] + p;
    end
    if (op == PE_OUT)
    begin
      exp_data_q.push_back(expected_vector());
      exp_edge_q.push_back(edge_count + 3);  // sampled next edge, strobe two later
    end
  endtask

  // ==================================================
  // drivers
  // ==================================================
  task automatic send_cmd(input pe_op_t op, input wb_rd_addr_t addr, input vec_t data,
                          input pe_mask_t mask);
    pe_op        = op;
    wb_read_addr = addr;
    vec_data     = data;
    vec_mask     = mask;
    apply_cmd(op, addr, data, mask);
    @(posedge clk);
    #2;
    pe_op = PE_IDLE;
  endtask

  task automatic bus_word(input read_id_t id, input bus_word_t data);
    logic exp_req;
    exp_req         = (id == read_id_t'(PU_ID));
    read_data       = data;
    read_id         = id;
    read_data_valid = 1'b1;
    @(negedge clk);
    assert (read_req === exp_req)
      else fail_stop($sformatf("FAILED read_req: got %h expected %h", read_req, exp_req));
    if (exp_req)
    begin
      if (!ref_bias_seen)
        ref_loaded_bias = data[OP_W-1:0];
      else
      begin
        ref_mem[ref_wr_addr] = data;
        ref_wr_addr = ref_wr_addr + 1'b1;
      end
      ref_bias_seen = 1'b1;
    end
    @(posedge clk);
    #2;
    read_data_valid = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n)
    begin
      @(negedge clk);
      assert (read_req === 1'b0)
        else fail_stop($sformatf("FAILED read_req: got %h expected %h", read_req, 1'b0));
      @(posedge clk);
      #2;
    end
  endtask

  task automatic commit_bias();
    bias_read_req   = 1'b1;
    ref_active_bias = ref_loaded_bias;
    ref_bias_seen   = 1'b0;
    ref_wr_addr     = '0;
    @(posedge clk);
    #2;
    bias_read_req = 1'b0;
    idle_cycles(3);
  endtask

  // foreign words around every own word
  task automatic load_small(input int nwords);
    bus_word(read_id_t'($urandom_range(1, 15)), small_word());
    bus_word(read_id_t'(PU_ID), small_word());
    for (int k = 0; k < nwords; k++)
    begin
      bus_word(read_id_t'($urandom_range(1, 15)), small_word());
      bus_word(read_id_t'(PU_ID), small_word());
    end
    loaded_words = nwords;
    commit_bias();
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (exp_data_q.size() != 0)
    begin
      @(posedge clk);
      #2;
      cycles++;
      if (cycles > 10)
        fail_stop("timed out waiting for write_req");
    end
    idle_cycles(1);
  endtask

  // ==================================================
  // output checker
  // ==================================================
  always @(negedge clk)
  begin : check_outputs
    vec_t        exp_data;
    int unsigned exp_edge;
    if (!reset)
    begin
      assert (i_pu_top.u_props.fail_count == 0)
        else fail_stop("a bound property on pu_top failed");
      assert (!$isunknown(write_req))
        else fail_stop("write_req is unknown after reset");
      if (write_req)
      begin
        assert (exp_data_q.size() != 0)
          else fail_stop("write_req went high with no PE_OUT pending");
        exp_data = exp_data_q.pop_front();
        exp_edge = exp_edge_q.pop_front();
        assert (edge_count == exp_edge)
          else fail_stop($sformatf("FAILED write_req edge: got %h expected %h",
                                   edge_count, exp_edge));
        assert (write_data === exp_data)
          else fail_stop($sformatf("FAILED write_data: got %h expected %h",
                                   write_data, exp_data));
      end
    end
  end

  initial
  begin
    void'($urandom(61415));
    reset           = 1'b1;
    bias_read_req   = 1'b0;
    read_data       = '0;
    read_id         = '0;
    read_data_valid = 1'b0;
    pe_op           = PE_IDLE;
    wb_read_addr    = '0;
    vec_data        = '0;
    vec_mask        = '0;
    ref_wr_addr     = '0;
    ref_bias_seen   = 1'b0;
    ref_loaded_bias = '0;
    ref_active_bias = '0;
    loaded_words    = 0;
    foreach (ref_acc[i])
      ref_acc[i] = 0;
    repeat (8) @(posedge clk);
    #2;
    reset = 1'b0;

    // quiet after reset, zero accumulators
    idle_cycles(4);
    send_cmd(PE_OUT, '0, '0, '0);
    wait_drain();

    // full-mask runs, then masked runs
    load_small(8);
    repeat (3)
    begin
      send_cmd(PE_CLEAR, rand_addr(), small_word(), 4'hf);
      repeat ($urandom_range(1, 6))
        send_cmd(PE_MAC, rand_addr(), small_word(), 4'hf);
      send_cmd(PE_OUT, '0, '0, '0);
      wait_drain();
    end
    repeat (4)
    begin
      send_cmd(PE_CLEAR, rand_addr(), small_word(), pe_mask_t'($urandom));
      repeat (4)
        send_cmd(PE_MAC, rand_addr(), small_word(), pe_mask_t'($urandom));
      send_cmd(PE_OUT, '0, '0, '0);
      wait_drain();
    end

    // saturation, lanes 7fff 7fff 8000 0001
    bus_word(read_id_t'(PU_ID), 64'h7000);
    bus_word(read_id_t'(PU_ID), {16'h0001, 16'h8000, 16'h7fff, 16'h7fff});
    loaded_words = 1;
    commit_bias();
    send_cmd(PE_CLEAR, 7'd0, {16'h0000, 16'h0001, 16'h8000, 16'h7fff}, 4'hf);
    send_cmd(PE_OUT, '0, '0, '0);
    send_cmd(PE_MAC, 7'd2, {4{16'h8000}}, 4'hf);
    send_cmd(PE_OUT, '0, '0, '0);
    wait_drain();

    // back to back, three in flight
    load_small(8);
    send_cmd(PE_CLEAR, rand_addr(), small_word(), 4'hf);
    send_cmd(PE_MAC, rand_addr(), small_word(), 4'hf);
    send_cmd(PE_OUT, '0, '0, '0);
    send_cmd(PE_MAC, rand_addr(), small_word(), 4'hf);
    send_cmd(PE_OUT, '0, '0, '0);
    send_cmd(PE_OUT, '0, '0, '0);
    repeat (24)
      send_cmd(pe_op_t'($urandom_range(0, 3)), rand_addr(), small_word(), pe_mask_t'($urandom));
    send_cmd(PE_OUT, '0, '0, '0);
    wait_drain();

    $display("All checks passed");
    $finish;
  end

endmodule
